// ==== filelist.f ====
hdl/busPkg.sv
hdl/fifoPkg.sv
hdl/dmaRequestSync.sv
hdl/busTermDecode.sv
hdl/cpuBusSm.sv
hdl/cpuDmaTop.sv
testbench/cpuDmaTb.sv

// ==== hdl/busPkg.sv ====
// Bus-cycle definitions for the CPU-side DMA master: machine states and port size
package busPkg;

    // Bus-master machine states
    // idle      bus released, waiting for a request or a flush end
    // request   breq driven, waiting for a free grant
    // acquire   bgack taken, breq dropped
    // address   address strobe phase
    // data      data strobe phase, waiting for termination
    // finish    strobes released, FIFO stepped
    // flushEnd  one-cycle stopFlush pulse
    typedef enum logic [2:0] {
        idle     = 3'd0,
        request  = 3'd1,
        acquire  = 3'd2,
        address  = 3'd3,
        data     = 3'd4,
        finish   = 3'd5,
        flushEnd = 3'd6
    } cpuState_t;

    // Termination kind as decoded from DSACK and STERM
    // portNone  nothing latched yet, or a DSACK0-only answer which is not handled
    // port16    DSACK1 alone, a word port
    // port32    both DSACK lines or STERM, a longword port
    typedef enum logic [1:0] {
        portNone = 2'd0,
        port16   = 2'd1,
        port32   = 2'd2
    } portSize_t;

endpackage

// ==== hdl/busTermDecode.sv ====
// Bus termination latch, decodes DSACK/STERM into a single termination pulse and port size
`timescale 1ns/10ps

module busTermDecode (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               dsack0_,
    input  logic               dsack1_,
    input  logic               sterm_,
    input  logic               cycleOpen,
    output logic               termValid,
    output busPkg::portSize_t  portSize
);

    logic stermLat_;
    logic dsack1Lat_;
    logic dsack0Lat_;
    logic termDone;

    // Latch follows the lines only while a data strobe is out
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            stermLat_  <= 1'b1;
            dsack1Lat_ <= 1'b1;
            dsack0Lat_ <= 1'b1;
            termDone   <= 1'b0;
        end else if (cycleOpen) begin
            stermLat_  <= sterm_;
            dsack1Lat_ <= dsack1_;
            dsack0Lat_ <= dsack0_;
            // Slave holds its answer until pds falls, so report it once
            termDone   <= termDone || termValid;
        end else begin
            stermLat_  <= 1'b1;
            dsack1Lat_ <= 1'b1;
            dsack0Lat_ <= 1'b1;
            termDone   <= 1'b0;
        end
    end

    // Synchronous termination or both DSACKs is a longword port
    always_comb begin
        if (!stermLat_ || (!dsack1Lat_ && !dsack0Lat_)) begin
            portSize = busPkg::port32;
        end else if (!dsack1Lat_) begin
            portSize = busPkg::port16;
        end else begin
            portSize = busPkg::portNone;
        end
    end

    assign termValid = (portSize != busPkg::portNone) && !termDone;

    // No 8-bit slaves sit on this bus
    assert property (@(posedge BCLK) disable iff (!CCRESET_)
        cycleOpen |-> !(dsack1_ && !dsack0_))
        else $error("busTermDecode: DSACK0-only termination during a bus cycle");

endmodule

// ==== hdl/cpuBusSm.sv ====
// CPU bus-master state machine, runs longword DMA cycles and strobes the FIFO
`timescale 1ns/10ps

module cpuBusSm (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               xferDue,
    input  logic               lastWord,
    input  logic               grantFree,
    input  logic               termValid,
    input  busPkg::portSize_t  portSize,
    input  fifoPkg::dmaDir_t   dmaDir,
    output logic               cycleOpen,
    output logic               breq,
    output logic               bgack,
    output logic               pas,
    output logic               pds,
    output logic               size1,
    output logic               plhw,
    output logic               pllw,
    output logic               f2CpuH,
    output logic               f2CpuL,
    output logic               incFifo,
    output logic               decFifo,
    output logic               stopFlush,
    output busPkg::cpuState_t  state
);

    busPkg::cpuState_t   stateNext;
    fifoPkg::wordHalf_t  half;
    fifoPkg::wordHalf_t  halfNext;
    logic                toFifoDir;
    logic                termEnd;
    logic                breqD;
    logic                bgackD;
    logic                pasD;
    logic                pdsD;
    logic                size1D;
    logic                plhwD;
    logic                pllwD;
    logic                f2CpuHD;
    logic                f2CpuLD;
    logic                incFifoD;
    logic                decFifoD;
    logic                stopFlushD;

    assign toFifoDir = (dmaDir == fifoPkg::toFifo);
    assign termEnd   = (state == busPkg::data) && termValid;

    always_comb begin
        stateNext = state;
        halfNext  = half;
        case (state)
            busPkg::idle: begin
                // A finished flush wins over a new request
                if (lastWord) begin
                    stateNext = busPkg::flushEnd;
                end else if (xferDue) begin
                    stateNext = busPkg::request;
                end
            end
            busPkg::request: begin
                if (grantFree) begin
                    stateNext = busPkg::acquire;
                end
            end
            busPkg::acquire: stateNext = busPkg::address;
            busPkg::address: stateNext = busPkg::data;
            busPkg::data: begin
                if (termValid) begin
                    if (portSize == busPkg::port16 && half == fifoPkg::highHalf) begin
                        stateNext = busPkg::address;
                        halfNext  = fifoPkg::lowHalf;
                    end else begin
                        stateNext = busPkg::finish;
                    end
                end
            end
            busPkg::finish: begin
                stateNext = busPkg::idle;
                halfNext  = fifoPkg::highHalf;
            end
            default: stateNext = busPkg::idle;
        endcase
    end

    // Outputs are registered, decoded from where the machine is going
    always_comb begin
        breqD  = (stateNext == busPkg::request);
        bgackD = (stateNext == busPkg::acquire) || (stateNext == busPkg::address) ||
                 (stateNext == busPkg::data);
        // AS negates for the address phase of the low half
        pasD   = ((stateNext == busPkg::address) && (state != busPkg::data)) ||
                 (stateNext == busPkg::data);
        pdsD   = (stateNext == busPkg::data);
        size1D = ((stateNext == busPkg::address) || (stateNext == busPkg::data)) &&
                 (halfNext == fifoPkg::lowHalf);

        plhwD = toFifoDir && termEnd &&
                (portSize == busPkg::port32 || half == fifoPkg::highHalf);
        pllwD = toFifoDir && termEnd &&
                (portSize == busPkg::port32 || half == fifoPkg::lowHalf);

        // Port size is only known at termination, so the first data phase drives both halves
        f2CpuHD = !toFifoDir && (stateNext == busPkg::data) && (halfNext == fifoPkg::highHalf);
        f2CpuLD = !toFifoDir && (stateNext == busPkg::data);

        incFifoD   = toFifoDir && (stateNext == busPkg::finish);
        decFifoD   = !toFifoDir && (stateNext == busPkg::finish);
        stopFlushD = (stateNext == busPkg::flushEnd);
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state     <= busPkg::idle;
            half      <= fifoPkg::highHalf;
            breq      <= 1'b0;
            bgack     <= 1'b0;
            pas       <= 1'b0;
            pds       <= 1'b0;
            size1     <= 1'b0;
            plhw      <= 1'b0;
            pllw      <= 1'b0;
            f2CpuH    <= 1'b0;
            f2CpuL    <= 1'b0;
            incFifo   <= 1'b0;
            decFifo   <= 1'b0;
            stopFlush <= 1'b0;
        end else begin
            state     <= stateNext;
            half      <= halfNext;
            breq      <= breqD;
            bgack     <= bgackD;
            pas       <= pasD;
            pds       <= pdsD;
            size1     <= size1D;
            plhw      <= plhwD;
            pllw      <= pllwD;
            f2CpuH    <= f2CpuHD;
            f2CpuL    <= f2CpuLD;
            incFifo   <= incFifoD;
            decFifo   <= decFifoD;
            stopFlush <= stopFlushD;
        end
    end

    // Termination latch is held open exactly while the data strobe is out
    assign cycleOpen = pds;

    assert property (@(posedge BCLK) disable iff (!CCRESET_) pds |-> pas)
        else $error("cpuBusSm: data strobe without address strobe");
    assert property (@(posedge BCLK) disable iff (!CCRESET_) !(breq && bgack))
        else $error("cpuBusSm: bus request while bus is owned");
    assert property (@(posedge BCLK) disable iff (!CCRESET_) !(incFifo && decFifo))
        else $error("cpuBusSm: FIFO stepped in both directions");

endmodule

// ==== hdl/cpuDmaTop.sv ====
// CPU-side DMA bus master top, request synchronizer, termination decode and state machine
`timescale 1ns/10ps

module cpuDmaTop #(
    parameter int SYNC_STAGES = 2
) (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               dmaEna,
    input  logic               dreq_,
    input  logic               flushFifo,
    input  fifoPkg::dmaDir_t   dmaDir,
    input  logic               fifoEmpty,
    input  logic               fifoFull,
    input  logic               bgrant_,
    input  logic               bgackIn_,
    input  logic               as_,
    input  logic               dsack0_,
    input  logic               dsack1_,
    input  logic               sterm_,
    output logic               breq,
    output logic               bgack,
    output logic               pas,
    output logic               pds,
    output logic               size1,
    output logic               plhw,
    output logic               pllw,
    output logic               f2CpuH,
    output logic               f2CpuL,
    output logic               incFifo,
    output logic               decFifo,
    output logic               stopFlush,
    output busPkg::cpuState_t  state
);

    logic               xferDue;
    logic               lastWord;
    logic               grantFree;
    logic               termValid;
    logic               cycleOpen;
    busPkg::portSize_t  portSize;

    dmaRequestSync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) reqSync0 (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .dmaEna    (dmaEna),
        .dreq_     (dreq_),
        .flushFifo (flushFifo),
        .dmaDir    (dmaDir),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull),
        .bgrant_   (bgrant_),
        .bgackIn_  (bgackIn_),
        .as_       (as_),
        .xferDue   (xferDue),
        .lastWord  (lastWord),
        .grantFree (grantFree)
    );

    busTermDecode termDec0 (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .dsack0_   (dsack0_),
        .dsack1_   (dsack1_),
        .sterm_    (sterm_),
        .cycleOpen (cycleOpen),
        .termValid (termValid),
        .portSize  (portSize)
    );

    cpuBusSm busSm0 (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .xferDue   (xferDue),
        .lastWord  (lastWord),
        .grantFree (grantFree),
        .termValid (termValid),
        .portSize  (portSize),
        .dmaDir    (dmaDir),
        .cycleOpen (cycleOpen),
        .breq      (breq),
        .bgack     (bgack),
        .pas       (pas),
        .pds       (pds),
        .size1     (size1),
        .plhw      (plhw),
        .pllw      (pllw),
        .f2CpuH    (f2CpuH),
        .f2CpuL    (f2CpuL),
        .incFifo   (incFifo),
        .decFifo   (decFifo),
        .stopFlush (stopFlush),
        .state     (state)
    );

endmodule

// ==== hdl/dmaRequestSync.sv ====
// DMA request synchronizer, derives the transfer-due, flush-end and bus-free levels
`timescale 1ns/10ps

module dmaRequestSync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic              BCLK,
    input  logic              CCRESET_,
    input  logic              dmaEna,
    input  logic              dreq_,
    input  logic              flushFifo,
    input  fifoPkg::dmaDir_t  dmaDir,
    input  logic              fifoEmpty,
    input  logic              fifoFull,
    input  logic              bgrant_,
    input  logic              bgackIn_,
    input  logic              as_,
    output logic              xferDue,
    output logic              lastWord,
    output logic              grantFree
);

    localparam int NUM_IN = 8;
    // Inactive levels: enable off, request and grant negated, bus strobes high
    localparam logic [NUM_IN-1:0] IDLE_LEVELS = 8'b0100_0111;

    logic [NUM_IN-1:0] rawIn;
    logic [NUM_IN-1:0] syncChain [0:SYNC_STAGES-1];
    logic              sEna;
    logic              sDreq_;
    logic              sFlush;
    logic              sEmpty;
    logic              sFull;
    logic              sBgrant_;
    logic              sBgackIn_;
    logic              sAs_;
    logic              fifoReady;

    assign rawIn = {dmaEna, dreq_, flushFifo, fifoEmpty, fifoFull, bgrant_, bgackIn_, as_};

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                syncChain[i] <= IDLE_LEVELS;
            end
        end else begin
            syncChain[0] <= rawIn;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                syncChain[i] <= syncChain[i-1];
            end
        end
    end

    assign {sEna, sDreq_, sFlush, sEmpty, sFull, sBgrant_, sBgackIn_, sAs_} =
        syncChain[SYNC_STAGES-1];

    // Direction is a static register setting, so it is used unsynchronized
    assign fifoReady = (dmaDir == fifoPkg::toFifo) ? !sFull : !sEmpty;

    assign xferDue   = sEna && !sDreq_ && fifoReady;
    assign lastWord  = sFlush && sEmpty;

    // Grant held and no other master on the bus
    assign grantFree = !sBgrant_ && sAs_ && sBgackIn_;

endmodule

// ==== hdl/fifoPkg.sv ====
// FIFO-side definitions for the DMA master: transfer direction and word half
package fifoPkg;

    // Transfer direction as seen from the FIFO
    // toFifo    bus read, data latched into the FIFO
    // fromFifo  bus write, data driven out of the FIFO
    typedef enum logic {
        toFifo   = 1'b0,
        fromFifo = 1'b1
    } dmaDir_t;

    // Half of the longword on a 16-bit port
    // A 32-bit port stays in highHalf for the whole cycle
    typedef enum logic {
        highHalf = 1'b0,
        lowHalf  = 1'b1
    } wordHalf_t;

endpackage

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the DMA bus master testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cpuDmaTb \
    -Mdir "$BUILD_DIR" \
    -f filelist.f

"./$BUILD_DIR/VcpuDmaTb" | tee "$LOG_FILE"

if grep -q "=== FAIL ===" "$LOG_FILE"; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "=== PASS ===" "$LOG_FILE"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

// ==== testbench/cpuDmaTb.sv ====
// Testbench for the CPU-side DMA bus master with grant model, bus slave and directed tests
`timescale 1ns/10ps

module cpuDmaTb;

    localparam int CLK_HALF = 50;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 300;
    // Six tests of up to 300 cycles each plus reset and some margin
    localparam int MAX_CYCLES = TEST_COUNT * CYCLES_PER_TEST + 200;
    localparam int unsigned RAND_SEED = 32'hf07a5b07;
    localparam int MODE_DSACK32 = 0;
    localparam int MODE_DSACK16 = 1;
    localparam int MODE_STERM = 2;

    logic BCLK = 1'b0;
    logic CCRESET_;
    logic dmaEna;
    logic dreq_;
    logic flushFifo;
    fifoPkg::dmaDir_t dmaDir;
    logic fifoEmpty;
    logic fifoFull;
    logic bgrant_ = 1'b1;
    logic bgackIn_;
    logic as_;
    logic dsack0_ = 1'b1;
    logic dsack1_ = 1'b1;
    logic sterm_ = 1'b1;
    logic breq;
    logic bgack;
    logic pas;
    logic pds;
    logic size1;
    logic plhw;
    logic pllw;
    logic f2CpuH;
    logic f2CpuL;
    logic incFifo;
    logic decFifo;
    logic stopFlush;
    busPkg::cpuState_t state;

    logic pasPrev = 1'b0;
    logic pdsPrev = 1'b0;
    logic breqPrev = 1'b0;
    logic clearCounts;
    int slaveMode;
    int waitLeft = 0;
    int cycleCount = 0;
    int pasRises = 0;
    int pdsRises = 0;
    int breqRises = 0;
    int overlap = 0;
    int plhwCount = 0;
    int pllwCount = 0;
    int incCount = 0;
    int decCount = 0;
    int stopCount = 0;
    int size1Odd = 0;
    int size1Even = 0;
    int f2HOdd = 0;
    int f2HEven = 0;
    int f2LEven = 0;
    int errorCount = 0;
    int testErrors = 0;
    int checkCount = 0;
    int testsRun = 0;
    int testsFailed = 0;

    always #CLK_HALF BCLK = ~BCLK;

    cpuDmaTop #(.SYNC_STAGES(2)) dut0 (.*);

    // Arbiter grants whenever a request is out
    always @(posedge BCLK) begin
        bgrant_ <= !breq;
    end

    // Bus slave answers each data strobe after 0 to 3 wait states
    always @(posedge BCLK) begin
        if (!pds) begin
            dsack0_ <= 1'b1;
            dsack1_ <= 1'b1;
            sterm_  <= 1'b1;
        end else begin
            if (!pdsPrev) begin
                waitLeft = $urandom % 4;
            end else if (waitLeft > 0) begin
                waitLeft = waitLeft - 1;
            end
            if (waitLeft == 0) begin
                case (slaveMode)
                    MODE_DSACK32: begin
                        dsack0_ <= 1'b0;
                        dsack1_ <= 1'b0;
                    end
                    MODE_DSACK16: dsack1_ <= 1'b0;
                    default: sterm_ <= 1'b0;
                endcase
            end
        end
    end

    // Event counters cleared between tests
    always @(posedge BCLK) begin
        pasPrev  <= pas;
        pdsPrev  <= pds;
        breqPrev <= breq;
        if (clearCounts) begin
            pasRises = 0;
            pdsRises = 0;
            breqRises = 0;
            overlap = 0;
            plhwCount = 0;
            pllwCount = 0;
            incCount = 0;
            decCount = 0;
            stopCount = 0;
            size1Odd = 0;
            size1Even = 0;
            f2HOdd = 0;
            f2HEven = 0;
            f2LEven = 0;
        end else begin
            if (pas && !pasPrev) pasRises++;
            if (breq && !breqPrev) breqRises++;
            if (breq && bgack) overlap++;
            if (plhw) plhwCount++;
            if (pllw) pllwCount++;
            if (incFifo) incCount++;
            if (decFifo) decCount++;
            if (stopFlush) stopCount++;
            if (pds && !pdsPrev) begin
                pdsRises++;
                // Odd cycles carry the high half and even cycles the low half
                if (pdsRises % 2 == 1) begin
                    if (size1) size1Odd++;
                    if (f2CpuH) f2HOdd++;
                end else begin
                    if (size1) size1Even++;
                    if (f2CpuH) f2HEven++;
                    if (f2CpuL) f2LEven++;
                end
            end
        end
    end

    always @(posedge BCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkValue(input string sigName, input int actual, input int expected);
        checkCount++;
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, sigName, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic beginTest();
        testErrors = 0;
        @(negedge BCLK);
        clearCounts = 1'b1;
        @(negedge BCLK);
        clearCounts = 1'b0;
    endtask

    task automatic endTest(input string testName);
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %s passed", testName);
        end else begin
            testsFailed++;
            $display("Test %s failed with %0d mismatches", testName, testErrors);
        end
    endtask

    // One request per longword is dropped once the bus is requested
    task automatic moveLongword();
        @(posedge BCLK);
        dreq_ <= 1'b0;
        do @(negedge BCLK); while (!breq);
        @(posedge BCLK);
        dreq_ <= 1'b1;
        do @(negedge BCLK); while (!(incFifo || decFifo));
    endtask

    task automatic waitIdle();
        do @(negedge BCLK); while (state != busPkg::idle);
    endtask

    task automatic idleAfterReset();
        int busyCycles;
        busyCycles = 0;
        beginTest();
        // Request pending while the channel is disabled
        @(posedge BCLK);
        dreq_ <= 1'b0;
        repeat (20) begin
            @(negedge BCLK);
            if (breq || bgack || pas || pds || size1 || plhw || pllw || f2CpuH || f2CpuL ||
                incFifo || decFifo || stopFlush || state != busPkg::idle) begin
                busyCycles++;
            end
        end
        @(posedge BCLK);
        dreq_ <= 1'b1;
        checkValue("busy cycles after reset", busyCycles, 0);
        endTest("resetIdle");
    endtask

    task automatic dsack32Read();
        beginTest();
        @(posedge BCLK);
        dmaEna    <= 1'b1;
        dmaDir    <= fifoPkg::toFifo;
        slaveMode <= MODE_DSACK32;
        repeat (4) moveLongword();
        waitIdle();
        checkValue("pas rises", pasRises, 4);
        checkValue("plhw", plhwCount, 4);
        checkValue("pllw", pllwCount, 4);
        checkValue("incFifo", incCount, 4);
        checkValue("decFifo", decCount, 0);
        checkValue("breq with bgack", overlap, 0);
        endTest("dsack32Read");
    endtask

    task automatic dsack16Write();
        beginTest();
        @(posedge BCLK);
        dmaDir    <= fifoPkg::fromFifo;
        slaveMode <= MODE_DSACK16;
        repeat (3) moveLongword();
        waitIdle();
        checkValue("pas rises", pasRises, 6);
        checkValue("pds rises", pdsRises, 6);
        checkValue("size1 in odd cycles", size1Odd, 0);
        checkValue("size1 in even cycles", size1Even, 3);
        checkValue("f2CpuH in odd cycles", f2HOdd, 3);
        checkValue("f2CpuH in even cycles", f2HEven, 0);
        checkValue("f2CpuL in even cycles", f2LEven, 3);
        checkValue("decFifo", decCount, 3);
        checkValue("incFifo", incCount, 0);
        endTest("dsack16Write");
    endtask

    task automatic stermRead();
        beginTest();
        @(posedge BCLK);
        dmaDir    <= fifoPkg::toFifo;
        slaveMode <= MODE_STERM;
        repeat (3) moveLongword();
        waitIdle();
        checkValue("pds rises", pdsRises, 3);
        checkValue("plhw", plhwCount, 3);
        checkValue("pllw", pllwCount, 3);
        checkValue("incFifo", incCount, 3);
        endTest("stermRead");
    endtask

    task automatic fifoFullHold();
        beginTest();
        @(posedge BCLK);
        slaveMode <= MODE_DSACK32;
        fifoFull  <= 1'b1;
        dreq_     <= 1'b0;
        repeat (50) @(negedge BCLK);
        checkValue("breq rises while full", breqRises, 0);
        checkValue("incFifo while full", incCount, 0);
        @(posedge BCLK);
        fifoFull <= 1'b0;
        do @(negedge BCLK); while (!breq);
        @(posedge BCLK);
        dreq_ <= 1'b1;
        do @(negedge BCLK); while (!incFifo);
        waitIdle();
        checkValue("incFifo after release", incCount, 1);
        endTest("fifoFullHold");
    endtask

    task automatic flushWhenEmpty();
        beginTest();
        @(posedge BCLK);
        // A write request stays pending while the FIFO is empty
        dmaDir    <= fifoPkg::fromFifo;
        dreq_     <= 1'b0;
        fifoEmpty <= 1'b1;
        flushFifo <= 1'b1;
        // Flush request is a one-clock strobe from the DMA control register
        @(posedge BCLK);
        flushFifo <= 1'b0;
        do @(negedge BCLK); while (!stopFlush);
        repeat (20) @(negedge BCLK);
        checkValue("stopFlush", stopCount, 1);
        checkValue("breq rises", breqRises, 0);
        endTest("flushEmpty");
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        CCRESET_    = 1'b0;
        dmaEna      = 1'b0;
        dreq_       = 1'b1;
        flushFifo   = 1'b0;
        dmaDir      = fifoPkg::toFifo;
        fifoEmpty   = 1'b0;
        fifoFull    = 1'b0;
        // No other master on the bus
        bgackIn_    = 1'b1;
        as_         = 1'b1;
        slaveMode   = MODE_DSACK32;
        clearCounts = 1'b0;
        repeat (RESET_CYCLES) @(posedge BCLK);
        CCRESET_ <= 1'b1;
        idleAfterReset();
        dsack32Read();
        dsack16Write();
        stermRead();
        fifoFullHold();
        flushWhenEmpty();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
